// ==== src/reg_path_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the register write path.
// Field widths, the drop counter type and the
// write request struct carried by the slices.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package reg_path_pkg;

    localparam int ADDR_W = 8;   // Register address width.
    localparam int DATA_W = 32;  // One register word.
    localparam int STRB_W = DATA_W / 8;  // One strobe per byte lane.
    localparam int CNT_W  = 16;

    // Register address as seen on the host channel and on the readback port.
    typedef logic [ADDR_W-1:0] reg_addr_t;

    // Register value.
    typedef logic [DATA_W-1:0] reg_data_t;

    // Byte-lane strobes where bit b enables byte b of reg_data_t.
    typedef logic [STRB_W-1:0] reg_strb_t;

    // Count of writes dropped for an address outside the bank.
    typedef logic [CNT_W-1:0] err_cnt_t;

    // The counter stops here instead of wrapping.
    localparam err_cnt_t ERR_CNT_MAX = '1;

    // One write request of 44 bits in all.
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
        reg_strb_t strb;
    } wr_req_t;

endpackage

// ==== src/wr_ingress.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Ingress filter of the host write channel.
// Forwards in-range writes, swallows and counts
// the rest.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module wr_ingress
    import reg_path_pkg::*;
#(
    parameter int NUM_REGS = 16
)
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     host_valid,
    input  wr_req_t  host_req,
    output logic     host_ready,

    output logic     out_valid,
    output wr_req_t  out_req,
    input  logic     out_ready,

    output err_cnt_t drop_count
);

    logic in_range;
    logic drop;

    assign in_range = (int'(host_req.addr) < NUM_REGS);

    // The data path is pure wiring plus a mask on valid.
    assign out_valid = host_valid & in_range;
    assign out_req   = host_req;

    // A write that is going to be dropped never waits on the chain.
    assign host_ready = in_range ? out_ready : 1'b1;

    assign drop = host_valid & ~in_range; // Accepted and discarded this cycle.

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            drop_count <= '0;
        else if (drop && (drop_count != ERR_CNT_MAX))
            drop_count <= drop_count + 1'b1;
    end

    // A stalled request is held by the host until it is taken or withdrawn.
    a_host_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (host_valid && !host_ready) |=> (!host_valid || $stable(host_req))
    );

endmodule

// ==== src/reg_slice.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Two-entry ping-pong register slice carrying
// one write request per entry.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_slice
    import reg_path_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    in_valid,
    input  wr_req_t in_req,
    output logic    in_ready,

    output logic    out_valid,
    output wr_req_t out_req,
    input  logic    out_ready
);

    localparam int DEPTH = 2;

    wr_req_t          entry [DEPTH];
    logic [DEPTH-1:0] entry_valid;
    logic             wptr;          // Entry that takes the next write.
    logic             rptr;          // Entry that holds the oldest word.
    logic             push;
    logic             pop;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    // Full only when both entries hold a word, so a single stalled cycle
    // never blocks the upstream stage.
    assign in_ready  = ~(entry_valid[0] & entry_valid[1]);
    assign out_valid = entry_valid[0] | entry_valid[1];
    assign out_req   = entry[rptr];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            wptr <= 1'b0;
        else if (push)
            wptr <= ~wptr;
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            rptr <= 1'b0;
        else if (pop)
            rptr <= ~rptr;
    end

    always_ff @(posedge clk)
    begin
        if (push)
            entry[wptr] <= in_req;
    end

    // Push and pop never hit the same entry in one cycle.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            entry_valid <= '0;
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                if (push && (wptr == i[0]))
                    entry_valid[i] <= 1'b1;
                else if (pop && (rptr == i[0]))
                    entry_valid[i] <= 1'b0;
            end
        end
    end

    // A stalled word is held until the next stage takes it.
    a_out_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_req))
    );

endmodule

// ==== src/reg_bank.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register bank at the end of the write path.
// Byte-strobe merge, lock back-pressure and a
// combinational readback port.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_bank
    import reg_path_pkg::*;
#(
    parameter int NUM_REGS = 16
)
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      lock,

    input  logic      in_valid,
    input  wr_req_t   in_req,
    output logic      in_ready,

    input  reg_addr_t rd_addr,
    output reg_data_t rd_data
);

    localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

    reg_data_t        regs [NUM_REGS];
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    logic             wr_en;

    assign in_ready = ~lock;  // Lock stalls the whole chain behind it.
    assign wr_en    = in_valid & in_ready & (int'(in_req.addr) < NUM_REGS);
    assign wr_idx   = in_req.addr[IDX_W-1:0];
    assign rd_idx   = rd_addr[IDX_W-1:0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < NUM_REGS; r++)
                regs[r] <= '0;
        end
        else if (wr_en)
        begin
            // Only the strobed byte lanes take the new data.
            for (int b = 0; b < STRB_W; b++)
            begin
                if (in_req.strb[b])
                    regs[wr_idx][8*b +: 8] <= in_req.data[8*b +: 8];
            end
        end
    end

    // Addresses past the bank read as zero.
    assign rd_data = (int'(rd_addr) < NUM_REGS) ? regs[rd_idx] : '0;

    // With lock high on the previous edge nothing was written, so the
    // readback of a steady address cannot move.
    a_locked_no_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(lock) && $stable(rd_addr)) |-> $stable(rd_data)
    );

endmodule

// ==== src/reg_write_path.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the register write path.
// Ingress filter, STAGES register slices, bank.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_write_path
    import reg_path_pkg::*;
#(
    parameter int STAGES   = 3,
    parameter int NUM_REGS = 16
)
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      host_valid,
    input  wr_req_t   host_req,
    output logic      host_ready,

    input  logic      lock,

    input  reg_addr_t rd_addr,
    output reg_data_t rd_data,

    output err_cnt_t  drop_count
);

    // Link s feeds slice s, link STAGES feeds the bank.
    logic    link_valid [STAGES+1];
    wr_req_t link_req   [STAGES+1];
    logic    link_ready [STAGES+1];

    wr_ingress #(
        .NUM_REGS (NUM_REGS)
    ) wr_ingress_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_valid (host_valid),
        .host_req   (host_req),
        .host_ready (host_ready),
        .out_valid  (link_valid[0]),
        .out_req    (link_req[0]),
        .out_ready  (link_ready[0]),
        .drop_count (drop_count)
    );

    // One cycle of latency and two words of buffering per stage.
    for (genvar s = 0; s < STAGES; s++)
    begin : g_slice
        reg_slice reg_slice_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (link_valid[s]),
            .in_req    (link_req[s]),
            .in_ready  (link_ready[s]),
            .out_valid (link_valid[s+1]),
            .out_req   (link_req[s+1]),
            .out_ready (link_ready[s+1])
        );
    end

    reg_bank #(
        .NUM_REGS (NUM_REGS)
    ) reg_bank_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .lock     (lock),
        .in_valid (link_valid[STAGES]),
        .in_req   (link_req[STAGES]),
        .in_ready (link_ready[STAGES]),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

// ==== verification/reg_write_path_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the register write path.
// Step table, register model, typed compare
// tasks and a seeded LCG for random data.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_write_path_tb
    import reg_path_pkg::*;
;

    localparam int STAGES   = 3;
    localparam int NUM_REGS = 16;
    localparam int TIMEOUT  = 100;          // Cycles a write may wait for host_ready.
    localparam int HOLD     = 4 * STAGES;   // Cycles a blocked write is watched.

    localparam logic [1:0] STEP_WRITE = 2'd0;
    localparam logic [1:0] STEP_LOCK  = 2'd1;  // Sets the lock level from the row.
    localparam logic [1:0] STEP_PROBE = 2'd2;  // Offers a write that must stay blocked.
    localparam logic [1:0] STEP_CHECK = 2'd3;  // Drains and compares the whole bank.

    typedef struct packed {
        logic [1:0] kind;
        logic       lock;
        reg_addr_t  addr;
        reg_data_t  data;
        reg_strb_t  strb;
    } step_t;

    logic      clk;
    logic      rst_n;
    logic      host_valid;
    wr_req_t   host_req;
    logic      host_ready;
    logic      lock;
    reg_addr_t rd_addr;
    reg_data_t rd_data;
    err_cnt_t  drop_count;

    step_t       steps [$];
    reg_data_t   model [NUM_REGS];  // Expected register contents.
    err_cnt_t    drops_exp;
    int          held;              // In-range writes accepted while locked.
    logic [31:0] lcg_state = 32'h8905b901;

    reg_write_path #(
        .STAGES   (STAGES),
        .NUM_REGS (NUM_REGS)
    ) reg_write_path_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .host_valid (host_valid),
        .host_req   (host_req),
        .host_ready (host_ready),
        .lock       (lock),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .drop_count (drop_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Only the strobed byte lanes take the new value.
    function automatic reg_data_t merge_bytes(reg_data_t old_val, reg_data_t new_val,
                                              reg_strb_t strb);
        reg_data_t res;
        res = old_val;
        for (int b = 0; b < $bits(reg_strb_t); b++)
        begin
            if (strb[b])
                res[8*b +: 8] = new_val[8*b +: 8];
        end
        return res;
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "Simulation stopped on the first error.");
    endtask

    task automatic check_data(string name, reg_data_t got, reg_data_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_count(string name, err_cnt_t got, err_cnt_t exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                                $time, name, got, exp));
    endtask

    task automatic add_step(logic [1:0] kind, logic lk, reg_addr_t addr, reg_data_t data,
                            reg_strb_t strb);
        step_t st;
        st.kind = kind;
        st.lock = lk;
        st.addr = addr;
        st.data = data;
        st.strb = strb;
        steps.push_back(st);
    endtask

    task automatic build_table();
        add_step(STEP_CHECK, 1'b0, '0, '0, '0);  // Reset values.
        // Partial strobes on one register.
        add_step(STEP_WRITE, 1'b0, 8'd5, 32'h11223344, 4'b1111);
        add_step(STEP_WRITE, 1'b0, 8'd5, 32'haabbccdd, 4'b0101);
        add_step(STEP_WRITE, 1'b0, 8'd5, 32'h55667788, 4'b1000);
        add_step(STEP_WRITE, 1'b0, 8'd5, 32'hffffffff, 4'b0000);
        add_step(STEP_CHECK, 1'b0, '0, '0, '0);
        // Addresses past the bank are swallowed.
        add_step(STEP_WRITE, 1'b0, 8'(NUM_REGS), 32'hdeadbeef, 4'b1111);
        add_step(STEP_WRITE, 1'b0, 8'h80, 32'h01010101, 4'b1111);
        add_step(STEP_WRITE, 1'b0, 8'hff, 32'h12345678, 4'b0011);
        add_step(STEP_CHECK, 1'b0, '0, '0, '0);
        // Three back-to-back writes per address leave the last one in place.
        for (int a = 0; a < NUM_REGS; a++)
        begin
            for (int k = 0; k < 3; k++)
                add_step(STEP_WRITE, 1'b0, 8'(a), next_rand(), 4'b1111);
        end
        add_step(STEP_CHECK, 1'b0, '0, '0, '0);
        // Lock fills the chain, then unlock releases it in order.
        add_step(STEP_LOCK, 1'b1, '0, '0, '0);
        for (int k = 0; k < 2 * STAGES; k++)
            add_step(STEP_WRITE, 1'b0, 8'(3 + k % 2), next_rand(), 4'b1111);
        add_step(STEP_PROBE, 1'b0, 8'd7, 32'hcafef00d, 4'b1111);
        add_step(STEP_WRITE, 1'b0, 8'h40, 32'h0badf00d, 4'b1111);
        add_step(STEP_LOCK, 1'b0, '0, '0, '0);
        add_step(STEP_CHECK, 1'b0, '0, '0, '0);
    endtask

    // Starts and ends on a falling edge.
    task automatic apply_write(reg_addr_t addr, reg_data_t data, reg_strb_t strb);
        int waited;
        waited = 0;
        host_req.addr = addr;
        host_req.data = data;
        host_req.strb = strb;
        host_valid    = 1'b1;
        #1;
        while (!host_ready)
        begin
            if (waited >= TIMEOUT)
                abort_run("Timeout: host_ready never rose for an offered write.");
            @(negedge clk);
            #1;
            waited++;
        end
        @(negedge clk);  // The write was taken on the rising edge in between.
        host_valid = 1'b0;
        if (int'(addr) < NUM_REGS)
        begin
            model[int'(addr)] = merge_bytes(model[int'(addr)], data, strb);
            if (lock)
                held++;
        end
        else if (drops_exp != '1)
            drops_exp++;
    endtask

    task automatic probe_stall(reg_addr_t addr, reg_data_t data, reg_strb_t strb);
        host_req.addr = addr;
        host_req.data = data;
        host_req.strb = strb;
        host_valid    = 1'b1;
        for (int c = 0; c < HOLD; c++)
        begin
            #1;
            if (host_ready)
                abort_run("An in-range write was accepted while the locked chain was full.");
            @(negedge clk);
        end
        host_valid = 1'b0;  // Withdrawn, so the model is not touched.
        @(negedge clk);     // The host idles for a cycle before it offers another write.
    endtask

    task automatic verify_bank();
        // Held words leave the chain at one per cycle once lock drops.
        repeat (STAGES + 1 + held) @(negedge clk);
        held = 0;
        for (int r = 0; r <= NUM_REGS; r++)
        begin
            if (r < 256)
            begin
                rd_addr = 8'(r);
                #1;
                check_data($sformatf("rd_data[%0d]", r), rd_data,
                           (r < NUM_REGS) ? model[r] : '0);
                @(negedge clk);
            end
        end
        check_count("drop_count", drop_count, drops_exp);
    endtask

    initial
    begin
        step_t st;
        rst_n      = 1'b0;
        host_valid = 1'b0;
        host_req   = '0;
        lock       = 1'b0;
        rd_addr    = '0;
        drops_exp  = '0;
        held       = 0;
        for (int r = 0; r < NUM_REGS; r++)
            model[r] = '0;
        build_table();
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int i = 0; i < steps.size(); i++)
        begin
            st = steps[i];
            case (st.kind)
                STEP_WRITE: apply_write(st.addr, st.data, st.strb);
                STEP_LOCK:  lock = st.lock;
                STEP_PROBE: probe_stall(st.addr, st.data, st.strb);
                default:    verify_bank();
            endcase
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== reg_write_path.f ====
src/reg_path_pkg.sv
src/wr_ingress.sv
src/reg_slice.sv
src/reg_bank.sv
src/reg_write_path.sv
verification/reg_write_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compiles the register write path testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module reg_write_path_tb \
    -f reg_write_path.f

# A fatal check ends the run with a non-zero status, so the log decides.
./obj_dir/Vreg_write_path_tb > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "test passed" "$LOG"; then
    echo "Simulation ended without a result, see $LOG"
    exit 1
fi
exit 0
